/* video_pkg.sv */
// tilemap video definitions
`default_nettype none

package video_pkg;

    // raster and bus vector types
    typedef logic [8:0]  pos_t;
    typedef logic [7:0]  scroll_t;
    typedef logic [15:0] vram_addr_t;
    // bits 9..0 tile code, bits 13..10 palette
    typedef logic [15:0] vram_data_t;
    // tile code * 8 + row in tile
    typedef logic [12:0] rom_addr_t;
    // eight 4-bit pixels, leftmost in 31..28
    typedef logic [31:0] rom_data_t;
    // palette * 16 + colour, colour 0 is transparent
    typedef logic [7:0]  pxl_idx_t;
    // red in 11..8, green in 7..4, blue in 3..0
    typedef logic [11:0] rgb12_t;
    typedef logic [8:0]  cpu_addr_t;
    typedef logic [15:0] cpu_data_t;

    // horizontal geometry in pixel clocks
    localparam int h_active = 64;
    localparam int h_total  = 96;
    localparam int hs_start = 72;
    localparam int hs_end   = 80;

    // vertical geometry in lines
    localparam int v_active = 32;
    localparam int v_total  = 40;
    localparam int vs_start = 34;
    localparam int vs_end   = 36;

    // eight visible tiles plus one for fine scroll
    localparam int tiles_per_line = 9;
    // 32x32 tile map, 256x256 pixel plane
    localparam int map_cols = 32;

    // CPU register map
    localparam cpu_addr_t reg_hpos      = 9'd0;
    localparam cpu_addr_t reg_vpos      = 9'd1;
    localparam cpu_addr_t reg_vram_base = 9'd2;
    localparam cpu_addr_t reg_backdrop  = 9'd3;
    localparam cpu_addr_t reg_layer_en  = 9'd4;
    // address bit selecting a palette write
    localparam int pal_sel_bit = 8;

    // tile fetch sequence, one map read then one ROM read per tile
    typedef enum logic [2:0] {
        fs_idle,
        fs_map_req,
        fs_map_wait,
        fs_rom_req,
        fs_rom_wait
    } fetch_state_t;

endpackage

`default_nettype wire

/* video_timing.sv */
// raster timing generator
`timescale 1ns/100ps
`default_nettype none

module video_timing import video_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic pxl_cen,
    output pos_t hdump,
    output pos_t vdump,
    output pos_t vrender,
    output logic line_start,
    output logic HS,
    output logic VS,
    output logic HB,
    output logic VB
);

    logic h_last;
    logic v_last;

    assign h_last = hdump == pos_t'(h_total - 1);
    assign v_last = vdump == pos_t'(v_total - 1);

    // counters come out of reset at the last pixel of the frame,
    // so both blanks are active until the first wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= pos_t'(h_total - 1);
            vdump <= pos_t'(v_total - 1);
        end else if (pxl_cen) begin
            if (h_last) begin
                hdump <= '0;
                if (v_last) begin
                    vdump <= '0;
                end else begin
                    vdump <= vdump + pos_t'(1);
                end
            end else begin
                hdump <= hdump + pos_t'(1);
            end
        end
    end

    // strobe on the clock that takes hdump back to 0
    assign line_start = pxl_cen && h_last;

    // line being prepared by the scroll fetch
    assign vrender = v_last ? '0 : vdump + pos_t'(1);

    // sync pulses
    assign HS = hdump >= pos_t'(hs_start) && hdump < pos_t'(hs_end);
    assign VS = vdump >= pos_t'(vs_start) && vdump < pos_t'(vs_end);

    // blanking outside the active window
    assign HB = hdump >= pos_t'(h_active);
    assign VB = vdump >= pos_t'(v_active);

    hdump_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        hdump < pos_t'(h_total)
    ) else $error("hdump left the line");

endmodule

`default_nettype wire

/* video_mmr.sv */
// CPU video registers
`timescale 1ns/100ps
`default_nettype none

module video_mmr import video_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cpu_cs,
    input  logic       cpu_we,
    input  cpu_addr_t  cpu_addr,
    input  cpu_data_t  cpu_wdata,
    output cpu_data_t  cpu_rdata,
    output scroll_t    hpos,
    output scroll_t    vpos,
    output vram_addr_t vram_base,
    output pxl_idx_t   backdrop,
    output logic       layer_en,
    output logic       pal_we,
    output pxl_idx_t   pal_idx,
    output rgb12_t     pal_rgb
);

    logic      wr_cyc;
    logic      rd_cyc;
    logic      pal_sel;
    cpu_data_t rd_mux;

    assign wr_cyc  = cpu_cs && cpu_we;
    assign rd_cyc  = cpu_cs && !cpu_we;
    assign pal_sel = cpu_addr[pal_sel_bit];

    // register writes, palette addresses never match the map
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hpos      <= '0;
            vpos      <= '0;
            vram_base <= '0;
            backdrop  <= '0;
            layer_en  <= 1'b0;
            pal_we    <= 1'b0;
        end else begin
            pal_we <= wr_cyc && pal_sel;
            if (wr_cyc) begin
                case (cpu_addr)
                    reg_hpos:      hpos      <= cpu_wdata[7:0];
                    reg_vpos:      vpos      <= cpu_wdata[7:0];
                    reg_vram_base: vram_base <= cpu_wdata;
                    reg_backdrop:  backdrop  <= cpu_wdata[7:0];
                    reg_layer_en:  layer_en  <= cpu_wdata[0];
                    default:       ;
                endcase
            end
        end
    end

    // palette entry and colour ride along with the strobe
    always_ff @(posedge clk) begin
        if (wr_cyc && pal_sel) begin
            pal_idx <= cpu_addr[7:0];
            pal_rgb <= cpu_wdata[11:0];
        end
    end

    // readback, palette and unmapped addresses give 0
    always_comb begin
        case (cpu_addr)
            reg_hpos:      rd_mux = cpu_data_t'(hpos);
            reg_vpos:      rd_mux = cpu_data_t'(vpos);
            reg_vram_base: rd_mux = vram_base;
            reg_backdrop:  rd_mux = cpu_data_t'(backdrop);
            reg_layer_en:  rd_mux = cpu_data_t'(layer_en);
            default:       rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_rdata <= '0;
        end else if (rd_cyc) begin
            cpu_rdata <= rd_mux;
        end
    end

    cpu_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        cpu_cs |-> !$isunknown(cpu_addr)
    ) else $error("CPU access with unknown address");

endmodule

`default_nettype wire

/* scroll_layer.sv */
// 8x8 tile scroll layer
`timescale 1ns/100ps
`default_nettype none

module scroll_layer import video_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic       line_start,
    input  pos_t       vrender,
    input  pos_t       hdump,
    input  scroll_t    hpos,
    input  scroll_t    vpos,
    input  vram_addr_t vram_base,
    input  logic       layer_en,
    output vram_addr_t vram_addr,
    output logic       vram_cs,
    input  vram_data_t vram_data,
    input  logic       vram_ok,
    output rom_addr_t  rom_addr,
    output logic       rom_cs,
    input  rom_data_t  rom_data,
    input  logic       rom_ok,
    output pxl_idx_t   pxl
);

    fetch_state_t fetch_st;
    logic         start_dly;
    logic         wr_half;
    logic [3:0]   tile_k;
    // vertical position inside the 256 line plane
    scroll_t      fetch_v;
    logic [4:0]   col_base;
    logic [4:0]   map_col;
    logic [9:0]   tile_code;
    logic [3:0]   tile_pal;
    logic [6:0]   rd_idx;
    // two halves of 72 pixels, wr_half is being filled
    pxl_idx_t     line_buf [0:1][0:71];

    // fetch for vrender starts one clock after the strobe,
    // once the counters have moved to the new line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_st  <= fs_idle;
            start_dly <= 1'b0;
            wr_half   <= 1'b0;
            tile_k    <= '0;
            fetch_v   <= '0;
            col_base  <= '0;
        end else begin
            start_dly <= line_start;
            if (line_start) begin
                wr_half <= ~wr_half;
            end
            case (fetch_st)
                fs_idle: begin
                    if (start_dly) begin
                        fetch_v  <= vrender[7:0] + vpos;
                        col_base <= hpos[7:3];
                        tile_k   <= '0;
                        fetch_st <= fs_map_req;
                    end
                end
                fs_map_req: fetch_st <= fs_map_wait;
                fs_map_wait: begin
                    if (vram_ok) begin
                        fetch_st <= fs_rom_req;
                    end
                end
                fs_rom_req: fetch_st <= fs_rom_wait;
                fs_rom_wait: begin
                    if (rom_ok) begin
                        tile_k <= tile_k + 4'd1;
                        if (tile_k == 4'(tiles_per_line - 1)) begin
                            fetch_st <= fs_idle;
                        end else begin
                            fetch_st <= fs_map_req;
                        end
                    end
                end
                default: fetch_st <= fs_idle;
            endcase
        end
    end

    // map entry and tile row into the back half
    always_ff @(posedge clk) begin
        if (fetch_st == fs_map_wait && vram_ok) begin
            tile_code <= vram_data[9:0];
            tile_pal  <= vram_data[13:10];
        end
        if (fetch_st == fs_rom_wait && rom_ok) begin
            for (int i = 0; i < 8; i++) begin
                line_buf[wr_half][7'({tile_k, 3'b000}) + 7'(i)] <=
                    {tile_pal, rom_data[31 - 4 * i -: 4]};
            end
        end
    end

    // column wraps at 32 tiles
    assign map_col   = col_base + {1'b0, tile_k};
    assign vram_cs   = fetch_st == fs_map_req;
    assign vram_addr = vram_base + vram_addr_t'(fetch_v[7:3]) * vram_addr_t'(map_cols)
                     + vram_addr_t'(map_col);
    assign rom_cs    = fetch_st == fs_rom_req;
    assign rom_addr  = {tile_code, fetch_v[2:0]};

    // fine scroll picks the start inside the first tile
    assign rd_idx = {1'b0, hdump[5:0]} + {4'd0, hpos[2:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            if (layer_en && hdump < pos_t'(h_active)) begin
                pxl <= line_buf[~wr_half][rd_idx];
            end else begin
                pxl <= '0;
            end
        end
    end

    // whole line fetch must fit before the halves swap
    fetch_in_time: assert property (
        @(posedge clk) disable iff (!rst_n)
        line_start |-> fetch_st == fs_idle
    ) else $error("tile fetch still running at line start");

endmodule

`default_nettype wire

/* colmix.sv */
// palette and colour output
`timescale 1ns/100ps
`default_nettype none

module colmix import video_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic       HB,
    input  logic       VB,
    input  pxl_idx_t   pxl,
    input  pxl_idx_t   backdrop,
    input  logic       pal_we,
    input  pxl_idx_t   pal_idx,
    input  rgb12_t     pal_rgb,
    output logic       LHBL_dly,
    output logic       LVBL_dly,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue
);

    rgb12_t   pal_ram [0:255];
    pxl_idx_t col_idx;
    rgb12_t   col_rgb;
    // blanks aligned with pxl
    logic     hb1;
    logic     vb1;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_idx] <= pal_rgb;
        end
    end

    // transparent colour shows the backdrop entry
    assign col_idx = (pxl[3:0] == 4'd0) ? backdrop : pxl;
    assign col_rgb = pal_ram[col_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hb1      <= 1'b1;
            vb1      <= 1'b1;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            hb1      <= HB;
            vb1      <= VB;
            LHBL_dly <= ~hb1;
            LVBL_dly <= ~vb1;
            if (hb1 || vb1) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                // 4 to 8 bits by repeating the nibble
                red   <= {col_rgb[11:8], col_rgb[11:8]};
                green <= {col_rgb[7:4], col_rgb[7:4]};
                blue  <= {col_rgb[3:0], col_rgb[3:0]};
            end
        end
    end

endmodule

`default_nettype wire

/* video_top.sv */
// tilemap video subsystem
`timescale 1ns/100ps
`default_nettype none

module video_top import video_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    // CPU bus
    input  logic       cpu_cs,
    input  logic       cpu_we,
    input  cpu_addr_t  cpu_addr,
    input  cpu_data_t  cpu_wdata,
    output cpu_data_t  cpu_rdata,
    // raster position
    output pos_t       hdump,
    output pos_t       vdump,
    output pos_t       vrender,
    // tile map memory
    output vram_addr_t vram_addr,
    output logic       vram_cs,
    input  vram_data_t vram_data,
    input  logic       vram_ok,
    // graphics ROM
    output rom_addr_t  rom_addr,
    output logic       rom_cs,
    input  rom_data_t  rom_data,
    input  logic       rom_ok,
    // video out
    output logic       HS,
    output logic       VS,
    output logic       HB,
    output logic       VB,
    output logic       LHBL_dly,
    output logic       LVBL_dly,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue
);

    scroll_t    hpos;
    scroll_t    vpos;
    vram_addr_t vram_base;
    pxl_idx_t   backdrop;
    logic       layer_en;
    logic       pal_we;
    pxl_idx_t   pal_idx;
    rgb12_t     pal_rgb;
    logic       line_start;
    pxl_idx_t   pxl;

    video_timing u_timing (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .hdump      (hdump),
        .vdump      (vdump),
        .vrender    (vrender),
        .line_start (line_start),
        .HS         (HS),
        .VS         (VS),
        .HB         (HB),
        .VB         (VB)
    );

    video_mmr u_mmr (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_cs     (cpu_cs),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_rdata  (cpu_rdata),
        .hpos       (hpos),
        .vpos       (vpos),
        .vram_base  (vram_base),
        .backdrop   (backdrop),
        .layer_en   (layer_en),
        .pal_we     (pal_we),
        .pal_idx    (pal_idx),
        .pal_rgb    (pal_rgb)
    );

    scroll_layer u_scroll (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .line_start (line_start),
        .vrender    (vrender),
        .hdump      (hdump),
        .hpos       (hpos),
        .vpos       (vpos),
        .vram_base  (vram_base),
        .layer_en   (layer_en),
        .vram_addr  (vram_addr),
        .vram_cs    (vram_cs),
        .vram_data  (vram_data),
        .vram_ok    (vram_ok),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .pxl        (pxl)
    );

    colmix u_colmix (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .HB         (HB),
        .VB         (VB),
        .pxl        (pxl),
        .backdrop   (backdrop),
        .pal_we     (pal_we),
        .pal_idx    (pal_idx),
        .pal_rgb    (pal_rgb),
        .LHBL_dly   (LHBL_dly),
        .LVBL_dly   (LVBL_dly),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

endmodule

`default_nettype wire

/* tb_video.sv */
// tilemap video testbench
`timescale 1ns/100ps
`default_nettype none

module tb_video import video_pkg::*; ();

    localparam int n_rows      = 5;
    localparam int frame_ticks = h_total * v_total;
    // one frame per row plus a spare one, four clocks per pixel
    localparam int timeout_lim = (n_rows + 1) * frame_ticks * 4 + 1000;

    logic       clk;
    logic       rst_n;
    logic       pxl_cen;
    logic       cpu_cs;
    logic       cpu_we;
    cpu_addr_t  cpu_addr;
    cpu_data_t  cpu_wdata;
    cpu_data_t  cpu_rdata;
    pos_t       hdump;
    pos_t       vdump;
    pos_t       vrender;
    vram_addr_t vram_addr;
    logic       vram_cs;
    vram_data_t vram_data;
    logic       vram_ok;
    rom_addr_t  rom_addr;
    logic       rom_cs;
    rom_data_t  rom_data;
    logic       rom_ok;
    logic       HS;
    logic       VS;
    logic       HB;
    logic       VB;
    logic       LHBL_dly;
    logic       LVBL_dly;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;

    // register settings per frame
    string      tbl_name [0:n_rows-1] = '{"zero_scroll", "fine_scroll", "wrap_scroll",
                                          "layer_off", "coarse_scroll"};
    scroll_t    tbl_hpos [0:n_rows-1] = '{8'h00, 8'h03, 8'hfb, 8'h11, 8'h48};
    scroll_t    tbl_vpos [0:n_rows-1] = '{8'h00, 8'h05, 8'hf6, 8'h22, 8'h10};
    vram_addr_t tbl_base [0:n_rows-1] = '{16'h0000, 16'h0400, 16'hff00, 16'h1234, 16'h2000};
    pxl_idx_t   tbl_back [0:n_rows-1] = '{8'h30, 8'h51, 8'h70, 8'ha0, 8'hc5};
    logic       tbl_en   [0:n_rows-1] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1};

    vram_data_t vram_mem [0:65535];
    rom_data_t  rom_mem  [0:8191];
    rgb12_t     pal_model [0:255];

    logic [31:0] lcg_state;
    int          cyc_cnt;
    int          exp_h;
    int          exp_v;
    // raster position after each of the last three pixel ticks
    int          hist_h [0:2];
    int          hist_v [0:2];
    logic        cen_seen;
    int          vram_wait;
    vram_addr_t  vram_req;
    int          rom_wait;
    rom_addr_t   rom_req;

    video_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .cpu_cs    (cpu_cs),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .hdump     (hdump),
        .vdump     (vdump),
        .vrender   (vrender),
        .vram_addr (vram_addr),
        .vram_cs   (vram_cs),
        .vram_data (vram_data),
        .vram_ok   (vram_ok),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .HS        (HS),
        .VS        (VS),
        .HB        (HB),
        .VB        (VB),
        .LHBL_dly  (LHBL_dly),
        .LVBL_dly  (LVBL_dly),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // memory answer delay of 1 to 6 clocks
    function automatic int pick_latency();
        logic [31:0] r;
        r = lcg_next();
        return 1 + int'(r[31:16]) % 6;
    endfunction

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rgb(input string name, input rgb12_t exp, input rgb12_t act);
        if (act !== exp) begin
            fail_stop($sformatf("[FAIL] %s: expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input cpu_data_t exp, input cpu_data_t act);
        if (act !== exp) begin
            fail_stop($sformatf("[FAIL] %s: expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic check_pos(input string name, input pos_t exp, input pos_t act);
        if (act !== exp) begin
            fail_stop($sformatf("[FAIL] %s: expected %0d, got %0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_stop($sformatf("[FAIL] %s: expected %b, got %b", name, exp, act));
        end
    endtask

    task automatic advance_position();
        if (exp_h == h_total - 1) begin
            exp_h = 0;
            exp_v = (exp_v == v_total - 1) ? 0 : exp_v + 1;
        end else begin
            exp_h = exp_h + 1;
        end
        hist_h[2] = hist_h[1];
        hist_v[2] = hist_v[1];
        hist_h[1] = hist_h[0];
        hist_v[1] = hist_v[0];
        hist_h[0] = exp_h;
        hist_v[0] = exp_v;
    endtask

    task automatic check_sync();
        check_pos("hdump", pos_t'(exp_h), hdump);
        check_pos("vdump", pos_t'(exp_v), vdump);
        check_pos("vrender", pos_t'((exp_v + 1) % v_total), vrender);
        check_bit("HS", exp_h >= hs_start && exp_h < hs_end, HS);
        check_bit("VS", exp_v >= vs_start && exp_v < vs_end, VS);
        check_bit("HB", exp_h >= h_active, HB);
        check_bit("VB", exp_v >= v_active, VB);
    endtask

    // single outstanding request, answered with a one-cycle ok
    task automatic serve_memories();
        vram_ok = 1'b0;
        rom_ok  = 1'b0;
        if (vram_wait > 0) begin
            vram_wait = vram_wait - 1;
            if (vram_wait == 0) begin
                vram_ok   = 1'b1;
                vram_data = vram_mem[vram_req];
            end
        end
        if (rom_wait > 0) begin
            rom_wait = rom_wait - 1;
            if (rom_wait == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_mem[rom_req];
            end
        end
        if (vram_cs) begin
            if (vram_wait > 0 || rom_wait > 0) begin
                fail_stop("VRAM request issued while another request was pending");
            end
            vram_req  = vram_addr;
            vram_wait = pick_latency();
        end
        if (rom_cs) begin
            if (vram_wait > 0 || rom_wait > 0) begin
                fail_stop("ROM request issued while another request was pending");
            end
            rom_req  = rom_addr;
            rom_wait = pick_latency();
        end
    endtask

    // one clock, inputs change 10 ns after the edge
    task automatic tick();
        logic cen_edge;
        cen_edge = pxl_cen && rst_n;
        @(posedge clk);
        #10;
        cyc_cnt = cyc_cnt + 1;
        if (cyc_cnt > timeout_lim) begin
            fail_stop("timeout: the frame checks did not finish in time");
        end
        pxl_cen  = (cyc_cnt % 4) == 3;
        cen_seen = cen_edge;
        if (cen_edge) begin
            advance_position();
        end
        if (rst_n) begin
            check_sync();
        end
        serve_memories();
    endtask

    task automatic wait_cen();
        do tick(); while (!cen_seen);
    endtask

    task automatic cpu_write(input cpu_addr_t addr, input cpu_data_t data);
        cpu_cs    = 1'b1;
        cpu_we    = 1'b1;
        cpu_addr  = addr;
        cpu_wdata = data;
        tick();
        cpu_cs = 1'b0;
        cpu_we = 1'b0;
    endtask

    task automatic cpu_read(input cpu_addr_t addr, input cpu_data_t exp, input string name);
        cpu_cs   = 1'b1;
        cpu_we   = 1'b0;
        cpu_addr = addr;
        tick();
        cpu_cs = 1'b0;
        check_word(name, exp, cpu_rdata);
    endtask

    task automatic fill_memories();
        logic [31:0] r1;
        logic [31:0] r2;
        for (int i = 0; i < 65536; i++) begin
            r1 = lcg_next();
            vram_mem[i] = r1[31:16];
        end
        for (int i = 0; i < 8192; i++) begin
            r1 = lcg_next();
            r2 = lcg_next();
            rom_mem[i] = {r1[31:16], r2[31:16]};
        end
    endtask

    task automatic load_palette();
        logic [31:0] r;
        logic [3:0]  p;
        cpu_data_t   data;
        for (int i = 0; i < 256; i++) begin
            r    = lcg_next();
            data = r[31:16];
            // backdrop candidates get a value unique to their palette
            if (i % 16 == 0) begin
                p    = 4'(i / 16);
                data = {4'h0, p, ~p, p ^ 4'ha};
            end
            cpu_write(cpu_addr_t'(256 + i), data);
            pal_model[i] = data[11:0];
        end
    endtask

    task automatic program_row(input int r);
        cpu_write(reg_hpos, {8'ha5, tbl_hpos[r]});
        cpu_write(reg_vpos, {8'h5a, tbl_vpos[r]});
        cpu_write(reg_vram_base, tbl_base[r]);
        cpu_write(reg_backdrop, {8'hc3, tbl_back[r]});
        cpu_write(reg_layer_en, {15'h0aa0, tbl_en[r]});
    endtask

    task automatic check_readback(input int r);
        cpu_read(reg_hpos, {8'h00, tbl_hpos[r]}, {tbl_name[r], " hpos readback"});
        cpu_read(reg_vpos, {8'h00, tbl_vpos[r]}, {tbl_name[r], " vpos readback"});
        cpu_read(reg_vram_base, tbl_base[r], {tbl_name[r], " vram_base readback"});
        cpu_read(reg_backdrop, {8'h00, tbl_back[r]}, {tbl_name[r], " backdrop readback"});
        cpu_read(reg_layer_en, {15'd0, tbl_en[r]}, {tbl_name[r], " layer_en readback"});
        cpu_read(cpu_addr_t'({1'b1, tbl_back[r]}), 16'h0000, {tbl_name[r], " palette read"});
    endtask

    // expected colour of the raster position two pixel ticks back
    task automatic check_output(input int r);
        int         h;
        int         v;
        int         px;
        int         py;
        vram_addr_t addr;
        vram_data_t entry;
        rom_data_t  bits;
        logic [3:0] colr;
        pxl_idx_t   idx;
        rgb12_t     exp_rgb;
        string      tag;
        h   = hist_h[2];
        v   = hist_v[2];
        tag = $sformatf("%s h=%0d v=%0d", tbl_name[r], h, v);
        check_bit({tag, " LHBL_dly"}, h < h_active, LHBL_dly);
        check_bit({tag, " LVBL_dly"}, v < v_active, LVBL_dly);
        if (h >= h_active || v >= v_active) begin
            exp_rgb = '0;
        end else begin
            idx = tbl_back[r];
            if (tbl_en[r]) begin
                px    = (h + int'(tbl_hpos[r])) % 256;
                py    = (v + int'(tbl_vpos[r])) % 256;
                addr  = tbl_base[r] + vram_addr_t'((py / 8) * map_cols + px / 8);
                entry = vram_mem[addr];
                bits  = rom_mem[rom_addr_t'(int'(entry[9:0]) * 8 + py % 8)];
                colr  = bits[31 - 4 * (px % 8) -: 4];
                if (colr != 4'd0) begin
                    idx = {entry[13:10], colr};
                end
            end
            exp_rgb = pal_model[idx];
        end
        check_rgb({tag, " rgb high"}, exp_rgb, {red[7:4], green[7:4], blue[7:4]});
        check_rgb({tag, " rgb low"}, exp_rgb, {red[3:0], green[3:0], blue[3:0]});
    endtask

    // lines from two after the current one are fetched with the new settings
    task automatic check_frame(input int r);
        int start_v;
        start_v = (exp_v + 2) % v_total;
        do tick(); while (!(cen_seen && hist_h[2] == 0 && hist_v[2] == start_v));
        for (int n = 0; n < frame_ticks; n++) begin
            if (n > 0) begin
                wait_cen();
            end
            check_output(r);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        pxl_cen   = 1'b0;
        cpu_cs    = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        vram_data = '0;
        vram_ok   = 1'b0;
        rom_data  = '0;
        rom_ok    = 1'b0;
        lcg_state = 32'd40;
        cyc_cnt   = 0;
        exp_h     = h_total - 1;
        exp_v     = v_total - 1;
        for (int i = 0; i < 3; i++) begin
            hist_h[i] = h_total - 1;
            hist_v[i] = v_total - 1;
        end
        cen_seen  = 1'b0;
        vram_wait = 0;
        rom_wait  = 0;
        vram_req  = '0;
        rom_req   = '0;
        fill_memories();
        repeat (10) tick();
        rst_n = 1'b1;
        load_palette();
        for (int r = 0; r < n_rows; r++) begin
            program_row(r);
            check_readback(r);
            check_frame(r);
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
video_pkg.sv
video_timing.sv
video_mmr.sv
scroll_layer.sv
colmix.sv
video_top.sv
tb_video.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_video -f vlog.f -o tb_video
out=$(./obj_dir/tb_video 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'No errors'; then
    exit 0
fi
exit 1
